// File: hw/rv_pkg.sv
// rv32i core package with shared word types and selector encodings
`default_nettype none

package rv_pkg;

  // data, address and instruction word
  typedef logic [31:0] word_t;
  // register file index
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_src_e;

  // writeback source, imm-plus is either imm or pc plus imm
  typedef enum logic [1:0] {
    RES_ALU     = 2'd0,
    RES_MEM     = 2'd1,
    RES_IMMPLUS = 2'd2,
    RES_PC4     = 2'd3
  } result_src_e;

  typedef enum logic [1:0] {
    PC_PC4    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JALR   = 2'd2
  } pc_src_e;

  // order follows the inputs of the execute-stage forwarding muxes
  typedef enum logic [1:0] {
    FWD_REG         = 2'd0,
    FWD_WB_RESULT   = 2'd1,
    FWD_MEM_IMMPLUS = 2'd2,
    FWD_MEM_ALU     = 2'd3
  } fwd_sel_e;

  localparam word_t RESET_PC_DEFAULT = 32'h0001_0000;

endpackage

`default_nettype wire

// File: hw/rv_if.sv
// control and hazard interfaces between decoder, datapath and hazard unit
`timescale 1ns/10ps
`default_nettype none

interface rv_ctrl_if import rv_pkg::*; ();

  imm_src_e    d_imm_src;
  alu_op_e     e_alu_op;
  logic        e_alu_src;
  logic        e_imm_plus_src;
  pc_src_e     e_pc_src;
  result_src_e w_result_src;
  logic        w_reg_write;

  // back from the datapath
  word_t       d_inst;
  logic        e_zero;
  logic        e_lt;
  logic        e_ltu;

  modport decoder (
    output d_imm_src, e_alu_op, e_alu_src, e_imm_plus_src, e_pc_src,
    output w_result_src, w_reg_write,
    input  d_inst, e_zero, e_lt, e_ltu
  );

  modport datapath (
    input  d_imm_src, e_alu_op, e_alu_src, e_imm_plus_src, e_pc_src,
    input  w_result_src, w_reg_write,
    output d_inst, e_zero, e_lt, e_ltu
  );

endinterface

interface rv_hazard_if import rv_pkg::*; (input logic clk);

  // register indices per stage
  reg_idx_t    d_rs1;
  reg_idx_t    d_rs2;
  reg_idx_t    e_rs1;
  reg_idx_t    e_rs2;
  reg_idx_t    e_rd;
  reg_idx_t    m_rd;
  reg_idx_t    w_rd;

  // stage control from the decoder
  logic        e_is_load;
  logic        m_reg_write;
  result_src_e m_result_src;
  logic        w_reg_write;
  pc_src_e     e_pc_src;

  logic        f_stall;
  logic        d_stall;
  logic        d_flush;
  logic        e_flush;
  fwd_sel_e    e_fwd1;
  fwd_sel_e    e_fwd2;

  modport datapath (
    output d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd,
    input  f_stall, d_stall, d_flush, e_flush, e_fwd1, e_fwd2
  );

  modport decoder (
    output e_is_load, m_reg_write, m_result_src, w_reg_write, e_pc_src
  );

  modport hazard (
    input  clk,
    input  d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd,
    input  e_is_load, m_reg_write, m_result_src, w_reg_write, e_pc_src,
    output f_stall, d_stall, d_flush, e_flush, e_fwd1, e_fwd2
  );

endinterface

`default_nettype wire

// File: hw/rv_alu.sv
// integer ALU with compare flags for branch resolution
`timescale 1ns/10ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  alu_op_e i_op,
  input  word_t   i_a,
  input  word_t   i_b,
  output word_t   o_y,
  output logic    o_zero,
  output logic    o_lt,
  output logic    o_ltu
);

  logic [32:0] diff;
  logic [4:0]  shamt;

  // flags always come from a - b, whatever the op
  assign diff   = {1'b0, i_a} - {1'b0, i_b};
  assign shamt  = i_b[4:0];
  assign o_zero = (diff[31:0] == '0);
  assign o_ltu  = diff[32];
  // signs differ: the negative operand is the smaller one
  assign o_lt   = (i_a[31] != i_b[31]) ? i_a[31] : diff[31];

  always_comb begin
    case (i_op)
      ALU_ADD:    o_y = i_a + i_b;
      ALU_SUB:    o_y = diff[31:0];
      ALU_SLL:    o_y = i_a << shamt;
      ALU_SLT:    o_y = {31'b0, o_lt};
      ALU_SLTU:   o_y = {31'b0, o_ltu};
      ALU_XOR:    o_y = i_a ^ i_b;
      ALU_SRL:    o_y = i_a >> shamt;
      ALU_SRA:    o_y = word_t'($signed(i_a) >>> shamt);
      ALU_OR:     o_y = i_a | i_b;
      ALU_AND:    o_y = i_a & i_b;
      ALU_PASS_B: o_y = i_b;
      default:    o_y = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
// 32 x 32 register file, two read ports with write-through, x0 tied to zero
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_we,
  input  reg_idx_t i_waddr,
  input  reg_idx_t i_raddr1,
  input  reg_idx_t i_raddr2,
  input  word_t    i_wdata,
  output word_t    o_rdata1,
  output word_t    o_rdata2
);

  // no storage for x0
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // writeback in the same cycle is seen by decode
  always_comb begin
    if (i_raddr1 == '0) begin
      o_rdata1 = '0;
    end else if (i_we && (i_raddr1 == i_waddr)) begin
      o_rdata1 = i_wdata;
    end else begin
      o_rdata1 = regs[i_raddr1];
    end
  end

  always_comb begin
    if (i_raddr2 == '0) begin
      o_rdata2 = '0;
    end else if (i_we && (i_raddr2 == i_waddr)) begin
      o_rdata2 = i_wdata;
    end else begin
      o_rdata2 = regs[i_raddr2];
    end
  end

  // writeback never presents an unknown index or value
  a_write_known: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_we |-> !$isunknown({i_waddr, i_wdata}));

endmodule

`default_nettype wire

// File: hw/rv_decoder.sv
// rv32i instruction decode, E/M/W control pipeline and branch resolution
`timescale 1ns/10ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  logic          clk,
  input  logic          i_rst_n,
  rv_ctrl_if.decoder    ctrl,
  rv_hazard_if.decoder  hz,
  input  logic          i_d_stall,
  input  logic          i_e_flush,
  output logic          o_dmem_we
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [6:0]  d_opcode;
  logic [2:0]  d_funct3;
  logic        d_funct7_b5;

  // decode stage fields
  logic        d_reg_write, d_mem_write, d_is_load;
  logic        d_branch, d_jal, d_jalr;
  logic        d_alu_src, d_imm_plus_src;
  alu_op_e     d_alu_op;
  result_src_e d_result_src;
  imm_src_e    d_imm_src;

  // execute stage copy
  logic        e_reg_write, e_mem_write, e_is_load;
  logic        e_branch, e_jal, e_jalr;
  logic        e_alu_src, e_imm_plus_src;
  alu_op_e     e_alu_op;
  result_src_e e_result_src;
  logic [2:0]  e_funct3;
  logic        e_taken;
  pc_src_e     e_pc_src;

  // memory and writeback copies
  logic        m_reg_write, m_mem_write;
  result_src_e m_result_src;
  logic        w_reg_write;
  result_src_e w_result_src;

  function automatic alu_op_e funct_alu_op(logic [2:0] funct3, logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign d_opcode    = ctrl.d_inst[6:0];
  assign d_funct3    = ctrl.d_inst[14:12];
  assign d_funct7_b5 = ctrl.d_inst[30];

  // unknown opcodes fall through as no-ops
  always_comb begin
    d_reg_write    = 1'b0;
    d_mem_write    = 1'b0;
    d_is_load      = 1'b0;
    d_branch       = 1'b0;
    d_jal          = 1'b0;
    d_jalr         = 1'b0;
    d_alu_src      = 1'b0;
    d_imm_plus_src = 1'b0;
    d_alu_op       = ALU_PASS_B;
    d_result_src   = RES_ALU;
    d_imm_src      = IMM_I;
    case (d_opcode)
      OPC_OP: begin
        d_reg_write = 1'b1;
        d_alu_op    = funct_alu_op(d_funct3, d_funct7_b5);
      end
      OPC_OPIMM: begin
        d_reg_write = 1'b1;
        d_alu_src   = 1'b1;
        // imm bit 30 only selects srai, never a subtract
        d_alu_op    = funct_alu_op(d_funct3, (d_funct3 == 3'b101) && d_funct7_b5);
      end
      OPC_LUI: begin
        d_reg_write  = 1'b1;
        d_imm_src    = IMM_U;
        d_result_src = RES_IMMPLUS;
      end
      OPC_AUIPC: begin
        d_reg_write    = 1'b1;
        d_imm_src      = IMM_U;
        d_imm_plus_src = 1'b1;
        d_result_src   = RES_IMMPLUS;
      end
      OPC_LOAD: begin
        d_reg_write  = 1'b1;
        d_is_load    = 1'b1;
        d_alu_src    = 1'b1;
        d_alu_op     = ALU_ADD;
        d_result_src = RES_MEM;
      end
      OPC_STORE: begin
        d_mem_write = 1'b1;
        d_alu_src   = 1'b1;
        d_alu_op    = ALU_ADD;
        d_imm_src   = IMM_S;
      end
      OPC_BRANCH: begin
        d_branch  = 1'b1;
        d_alu_op  = ALU_SUB;
        d_imm_src = IMM_B;
      end
      OPC_JAL: begin
        d_jal        = 1'b1;
        d_reg_write  = 1'b1;
        d_imm_src    = IMM_J;
        d_result_src = RES_PC4;
      end
      OPC_JALR: begin
        d_jalr       = 1'b1;
        d_reg_write  = 1'b1;
        d_alu_src    = 1'b1;
        d_alu_op     = ALU_ADD;
        d_result_src = RES_PC4;
      end
      default: begin
        d_reg_write = 1'b0;
      end
    endcase
  end

  // D/E control, flush inserts a bubble
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      e_reg_write <= 1'b0;
      e_mem_write <= 1'b0;
      e_is_load   <= 1'b0;
      e_branch    <= 1'b0;
      e_jal       <= 1'b0;
      e_jalr      <= 1'b0;
    end else if (i_e_flush) begin
      e_reg_write <= 1'b0;
      e_mem_write <= 1'b0;
      e_is_load   <= 1'b0;
      e_branch    <= 1'b0;
      e_jal       <= 1'b0;
      e_jalr      <= 1'b0;
    end else if (!i_d_stall) begin
      e_reg_write <= d_reg_write;
      e_mem_write <= d_mem_write;
      e_is_load   <= d_is_load;
      e_branch    <= d_branch;
      e_jal       <= d_jal;
      e_jalr      <= d_jalr;
    end
  end

  // selector payload, only meaningful next to a valid control bit
  always_ff @(posedge clk) begin
    if (!i_d_stall) begin
      e_alu_src      <= d_alu_src;
      e_imm_plus_src <= d_imm_plus_src;
      e_alu_op       <= d_alu_op;
      e_result_src   <= d_result_src;
      e_funct3       <= d_funct3;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      m_reg_write <= 1'b0;
      m_mem_write <= 1'b0;
      w_reg_write <= 1'b0;
    end else begin
      m_reg_write <= e_reg_write;
      m_mem_write <= e_mem_write;
      w_reg_write <= m_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    m_result_src <= e_result_src;
    w_result_src <= m_result_src;
  end

  // branch condition from funct3 and the ALU compare flags
  always_comb begin
    case (e_funct3)
      3'b000:  e_taken = ctrl.e_zero;
      3'b001:  e_taken = !ctrl.e_zero;
      3'b100:  e_taken = ctrl.e_lt;
      3'b101:  e_taken = !ctrl.e_lt;
      3'b110:  e_taken = ctrl.e_ltu;
      3'b111:  e_taken = !ctrl.e_ltu;
      default: e_taken = 1'b0;
    endcase
  end

  assign e_pc_src = e_jalr ? PC_JALR :
                    (e_jal || (e_branch && e_taken)) ? PC_BRANCH : PC_PC4;

  assign ctrl.d_imm_src      = d_imm_src;
  assign ctrl.e_alu_op       = e_alu_op;
  assign ctrl.e_alu_src      = e_alu_src;
  assign ctrl.e_imm_plus_src = e_imm_plus_src;
  assign ctrl.e_pc_src       = e_pc_src;
  assign ctrl.w_result_src   = w_result_src;
  assign ctrl.w_reg_write    = w_reg_write;

  assign hz.e_is_load    = e_is_load;
  assign hz.m_reg_write  = m_reg_write;
  assign hz.m_result_src = m_result_src;
  assign hz.w_reg_write  = w_reg_write;
  assign hz.e_pc_src     = e_pc_src;

  assign o_dmem_we = m_mem_write;

  // a jalr redirect needs a jalr decoded one cycle earlier
  a_jalr_origin: assert property (@(posedge clk) disable iff (!i_rst_n)
    (e_pc_src == PC_JALR) |-> $past(d_opcode == OPC_JALR));

endmodule

`default_nettype wire

// File: hw/rv_hazard.sv
// hazard unit: forwarding selects, load-use stall and redirect flushes
`timescale 1ns/10ps
`default_nettype none

module rv_hazard import rv_pkg::*; (
  rv_hazard_if.hazard hz
);

  logic load_use;
  logic redirect;

  // memory stage wins over writeback, x0 never forwards
  function automatic fwd_sel_e pick_fwd(reg_idx_t rs, reg_idx_t m_rd, logic m_we,
                                        result_src_e m_src, reg_idx_t w_rd, logic w_we);
    fwd_sel_e sel;
    sel = FWD_REG;
    if ((rs != '0) && m_we && (rs == m_rd)) begin
      sel = (m_src == RES_IMMPLUS) ? FWD_MEM_IMMPLUS : FWD_MEM_ALU;
    end else if ((rs != '0) && w_we && (rs == w_rd)) begin
      sel = FWD_WB_RESULT;
    end
    return sel;
  endfunction

  assign hz.e_fwd1 = pick_fwd(hz.e_rs1, hz.m_rd, hz.m_reg_write, hz.m_result_src,
                              hz.w_rd, hz.w_reg_write);
  assign hz.e_fwd2 = pick_fwd(hz.e_rs2, hz.m_rd, hz.m_reg_write, hz.m_result_src,
                              hz.w_rd, hz.w_reg_write);

  // load result not ready until it reaches writeback
  assign load_use = hz.e_is_load && (hz.e_rd != '0) &&
                    ((hz.e_rd == hz.d_rs1) || (hz.e_rd == hz.d_rs2));
  assign redirect = (hz.e_pc_src != PC_PC4);

  assign hz.f_stall = load_use;
  assign hz.d_stall = load_use;
  assign hz.d_flush = redirect;
  assign hz.e_flush = load_use || redirect;

  // a held pc would drop the redirect target
  a_no_stall_on_redirect: assert property (@(posedge hz.clk) !(hz.f_stall && hz.d_flush));

endmodule

`default_nettype wire

// File: hw/rv_datapath.sv
// five-stage rv32i datapath with PC, stage registers and forwarding
`timescale 1ns/10ps
`default_nettype none

module rv_datapath import rv_pkg::*; #(
  parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic          clk,
  input  logic          i_rst_n,
  rv_ctrl_if.datapath   ctrl,
  rv_hazard_if.datapath hz,
  input  word_t         i_inst,
  input  word_t         i_dmem_rdata,
  output word_t         o_pc,
  output word_t         o_dmem_addr,
  output word_t         o_dmem_wdata
);

  // fetch
  word_t    f_pc, f_pc4, f_pc_next;
  // decode
  word_t    d_inst, d_pc, d_pc4, d_imm, d_rd1, d_rd2;
  // execute
  word_t    e_rd1, e_rd2, e_imm, e_pc, e_pc4;
  word_t    e_src_a, e_wdata, e_src_b, e_alu_y, e_pc_imm, e_immplus;
  reg_idx_t e_rs1, e_rs2, e_rd;
  // memory
  word_t    m_alu, m_wdata, m_immplus, m_pc4;
  reg_idx_t m_rd;
  // writeback
  word_t    w_alu, w_mem, w_immplus, w_pc4, w_result;
  reg_idx_t w_rd;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t wb_val,
                                    word_t mem_immplus, word_t mem_alu);
    case (sel)
      FWD_WB_RESULT:   return wb_val;
      FWD_MEM_IMMPLUS: return mem_immplus;
      FWD_MEM_ALU:     return mem_alu;
      default:         return reg_val;
    endcase
  endfunction

  assign f_pc4 = f_pc + 32'd4;

  always_comb begin
    case (ctrl.e_pc_src)
      PC_BRANCH: f_pc_next = e_pc_imm;
      PC_JALR:   f_pc_next = {e_alu_y[31:1], 1'b0};
      default:   f_pc_next = f_pc4;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      f_pc <= RESET_PC;
    end else if (!hz.f_stall) begin
      f_pc <= f_pc_next;
    end
  end

  assign o_pc = f_pc;

  // IF/ID, an all-zero word decodes as a no-op
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      d_inst <= '0;
    end else if (hz.d_flush) begin
      d_inst <= '0;
    end else if (!hz.d_stall) begin
      d_inst <= i_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.d_stall) begin
      d_pc  <= f_pc;
      d_pc4 <= f_pc4;
    end
  end

  assign ctrl.d_inst = d_inst;
  assign hz.d_rs1    = d_inst[19:15];
  assign hz.d_rs2    = d_inst[24:20];

  rv_regfile regfile_i (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_we     (ctrl.w_reg_write),
    .i_waddr  (w_rd),
    .i_raddr1 (d_inst[19:15]),
    .i_raddr2 (d_inst[24:20]),
    .i_wdata  (w_result),
    .o_rdata1 (d_rd1),
    .o_rdata2 (d_rd2)
  );

  always_comb begin
    case (ctrl.d_imm_src)
      IMM_S:   d_imm = {{20{d_inst[31]}}, d_inst[31:25], d_inst[11:7]};
      IMM_B:   d_imm = {{20{d_inst[31]}}, d_inst[7], d_inst[30:25], d_inst[11:8], 1'b0};
      IMM_U:   d_imm = {d_inst[31:12], 12'b0};
      IMM_J:   d_imm = {{12{d_inst[31]}}, d_inst[19:12], d_inst[20], d_inst[30:21], 1'b0};
      default: d_imm = {{20{d_inst[31]}}, d_inst[31:20]};
    endcase
  end

  // ID/EX, cleared indices keep a bubble out of forwarding
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      e_rs1 <= '0;
      e_rs2 <= '0;
      e_rd  <= '0;
    end else if (hz.e_flush) begin
      e_rs1 <= '0;
      e_rs2 <= '0;
      e_rd  <= '0;
    end else begin
      e_rs1 <= d_inst[19:15];
      e_rs2 <= d_inst[24:20];
      e_rd  <= d_inst[11:7];
    end
  end

  always_ff @(posedge clk) begin
    e_rd1 <= d_rd1;
    e_rd2 <= d_rd2;
    e_imm <= d_imm;
    e_pc  <= d_pc;
    e_pc4 <= d_pc4;
  end

  assign hz.e_rs1 = e_rs1;
  assign hz.e_rs2 = e_rs2;
  assign hz.e_rd  = e_rd;

  always_comb begin
    e_src_a = fwd_mux(hz.e_fwd1, e_rd1, w_result, m_immplus, m_alu);
    e_wdata = fwd_mux(hz.e_fwd2, e_rd2, w_result, m_immplus, m_alu);
  end

  assign e_src_b = ctrl.e_alu_src ? e_imm : e_wdata;

  rv_alu alu_i (
    .i_op   (ctrl.e_alu_op),
    .i_a    (e_src_a),
    .i_b    (e_src_b),
    .o_y    (e_alu_y),
    .o_zero (ctrl.e_zero),
    .o_lt   (ctrl.e_lt),
    .o_ltu  (ctrl.e_ltu)
  );

  assign e_pc_imm  = e_pc + e_imm;
  assign e_immplus = ctrl.e_imm_plus_src ? e_pc_imm : e_imm;

  // EX/MEM
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      m_rd <= '0;
    end else begin
      m_rd <= e_rd;
    end
  end

  always_ff @(posedge clk) begin
    m_alu     <= e_alu_y;
    m_wdata   <= e_wdata;
    m_immplus <= e_immplus;
    m_pc4     <= e_pc4;
  end

  assign hz.m_rd        = m_rd;
  assign o_dmem_addr    = m_alu;
  assign o_dmem_wdata   = m_wdata;

  // MEM/WB, load data is a full word
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      w_rd <= '0;
    end else begin
      w_rd <= m_rd;
    end
  end

  always_ff @(posedge clk) begin
    w_alu     <= m_alu;
    w_mem     <= i_dmem_rdata;
    w_immplus <= m_immplus;
    w_pc4     <= m_pc4;
  end

  assign hz.w_rd = w_rd;

  always_comb begin
    case (ctrl.w_result_src)
      RES_MEM:     w_result = w_mem;
      RES_IMMPLUS: w_result = w_immplus;
      RES_PC4:     w_result = w_pc4;
      default:     w_result = w_alu;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
// rv32i pipelined core top with instruction and data memory ports
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
  input  logic  clk,
  input  logic  i_rst_n,
  input  word_t i_imem_data,
  input  word_t i_dmem_rdata,
  output word_t o_imem_addr,
  output word_t o_dmem_addr,
  output word_t o_dmem_wdata,
  output logic  o_dmem_we
);

  rv_ctrl_if   ctrl_if ();
  rv_hazard_if hz_if (.clk(clk));

  rv_decoder decoder_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .ctrl      (ctrl_if.decoder),
    .hz        (hz_if.decoder),
    .i_d_stall (hz_if.d_stall),
    .i_e_flush (hz_if.e_flush),
    .o_dmem_we (o_dmem_we)
  );

  rv_hazard hazard_i (
    .hz (hz_if.hazard)
  );

  rv_datapath #(
    .RESET_PC (RESET_PC)
  ) datapath_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .ctrl         (ctrl_if.datapath),
    .hz           (hz_if.datapath),
    .i_inst       (i_imem_data),
    .i_dmem_rdata (i_dmem_rdata),
    .o_pc         (o_imem_addr),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata)
  );

endmodule

`default_nettype wire

// File: tests/tb_rv_core.sv
// directed testbench for the rv32i pipelined core with memory models and store checks
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  localparam word_t RESET_PC    = 32'h0001_0000;
  localparam word_t END_ADDR    = 32'h0000_0FFC;
  localparam int    IMEM_WORDS  = 256;
  localparam int    RESET_CYCLES = 10;
  localparam int    RUN_LIMIT   = 200;
  localparam int    NUM_TESTS   = 5;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  logic  clk;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;
  logic  dmem_we;

  word_t imem [IMEM_WORDS];
  word_t dmem [1024];
  word_t got_addr[$];
  word_t got_data[$];
  word_t exp_addr[$];
  word_t exp_data[$];
  int    pc_idx;
  word_t st_addr;
  logic  done;
  int    errors;
  word_t lcg_state = 32'd70;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) rv_core_i (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_imem_data  (imem_data),
    .i_dmem_rdata (dmem_rdata),
    .o_imem_addr  (imem_addr),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // asynchronous fetch, a misaligned or out of range pc reads a no-op
  always_comb begin
    word_t off;
    off = (imem_addr - RESET_PC) >> 2;
    if ((imem_addr[1:0] != 2'b00) || (off >= IMEM_WORDS)) begin
      imem_data = '0;
    end else begin
      imem_data = imem[off[7:0]];
    end
  end

  assign dmem_rdata = dmem[dmem_addr[11:2]];

  // stores commit mid-cycle while the store sits in the memory stage
  always @(negedge clk) begin
    if (rst_n && dmem_we) begin
      dmem[dmem_addr[11:2]] = dmem_wdata;
      if (dmem_addr == END_ADDR) begin
        done = 1'b1;
      end else begin
        got_addr.push_back(dmem_addr);
        got_data.push_back(dmem_wdata);
      end
    end
  end

  initial begin
    #((NUM_TESTS * (RUN_LIMIT + RESET_CYCLES + 4)) * 20);
    $display("watchdog: simulation did not finish in the expected time");
    $display("TEST FAILED");
    $finish;
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // rv32i branch rule on two register values
  function automatic logic branch_taken(logic [2:0] f3, word_t x, word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic word_t pc_of(int idx);
    return RESET_PC + 32'(idx * 4);
  endfunction

  task automatic emit(word_t inst);
    if (pc_idx >= IMEM_WORDS) begin
      $display("%0t: program does not fit in instruction memory", $time);
      errors++;
    end else begin
      imem[pc_idx] = inst;
      pc_idx++;
    end
  endtask

  task automatic load_const(reg_idx_t rd, word_t v);
    word_t hi;
    hi = (v + 32'h800) >> 12;
    emit(enc_u(hi[19:0], rd, OPC_LUI));
    emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_OPIMM));
  endtask

  task automatic store_expect(reg_idx_t rs, word_t value);
    emit(enc_s(st_addr[11:0], rs, 5'd0));
    exp_addr.push_back(st_addr);
    exp_data.push_back(value);
    st_addr += 4;
  endtask

  task automatic op_check(word_t inst, reg_idx_t rd, word_t value);
    emit(inst);
    store_expect(rd, value);
  endtask

  // wrong-path pair, never expected in the store log
  task automatic emit_marker();
    emit(enc_i(12'h5A5, 5'd0, 3'b000, 5'd5, OPC_OPIMM));
    emit(enc_s(12'h7F0, 5'd5, 5'd0));
  endtask

  task automatic check_word(string what, word_t g_addr, word_t g_data,
                            word_t e_addr, word_t e_data);
    if ((g_addr !== e_addr) || (g_data !== e_data)) begin
      $display("MISMATCH %0t: %s store [%h]=%h, expected [%h]=%h",
               $time, what, g_addr, g_data, e_addr, e_data);
      errors++;
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
      $display("MISMATCH %0t: %s made %0d stores, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    if (imem_addr !== RESET_PC) begin
      $display("MISMATCH %0t: fetch address %h in reset, expected %h",
               $time, imem_addr, RESET_PC);
      errors++;
    end
    if (dmem_we !== 1'b0) begin
      $display("MISMATCH %0t: store enable high in reset", $time);
      errors++;
    end
  endtask

  // holds the core in reset while a new program is written
  task automatic begin_program();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = (word_t'(i) << 2) ^ 32'h5A5A_0000;
    end
    got_addr.delete();
    got_data.delete();
    exp_addr.delete();
    exp_data.delete();
    pc_idx  = 0;
    st_addr = 32'h100;
    done    = 1'b0;
  endtask

  task automatic run_program(string what);
    int cycles;
    emit(enc_u(20'h00001, 5'd31, OPC_LUI));
    emit(enc_s(12'hFFC, 5'd0, 5'd31));
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    cycles = 0;
    while (!done && (cycles < RUN_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("%0t: %s never reached its end store", $time, what);
      errors++;
    end
    check_count(what, got_addr.size(), exp_addr.size());
    for (int i = 0; (i < got_addr.size()) && (i < exp_addr.size()); i++) begin
      check_word(what, got_addr[i], got_data[i], exp_addr[i], exp_data[i]);
    end
  endtask

  task automatic test_arith();
    word_t a, b, s3, s4, s5, u;
    logic [11:0] imm;
    logic [4:0] sh, sh2;
    begin_program();
    a   = lcg_next();
    b   = lcg_next();
    imm = 12'(lcg_next() >> 7);
    sh  = b[4:0];
    sh2 = 5'(lcg_next() >> 20);
    u   = lcg_next();
    load_const(5'd1, a);
    load_const(5'd2, b);
    s3 = a + b;
    s4 = s3 - a;
    s5 = s3 ^ s4;
    // dependent chain without stores between
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd5));
    store_expect(5'd3, s3);
    store_expect(5'd4, s4);
    store_expect(5'd5, s5);
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd6), 5'd6, a << sh);
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd7), 5'd7, a >> sh);
    op_check(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd8), 5'd8, word_t'($signed(a) >>> sh));
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd9), 5'd9, word_t'($signed(a) < $signed(b)));
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd10), 5'd10, word_t'(a < b));
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 5'd11, a | b);
    op_check(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 5'd12, a & b);
    op_check(enc_i(imm, 5'd1, 3'b000, 5'd13, OPC_OPIMM), 5'd13, a + sext12(imm));
    op_check(enc_i(imm, 5'd1, 3'b010, 5'd14, OPC_OPIMM), 5'd14,
             word_t'($signed(a) < $signed(sext12(imm))));
    op_check(enc_i(imm, 5'd1, 3'b011, 5'd15, OPC_OPIMM), 5'd15, word_t'(a < sext12(imm)));
    op_check(enc_i(imm, 5'd1, 3'b100, 5'd16, OPC_OPIMM), 5'd16, a ^ sext12(imm));
    op_check(enc_i(imm, 5'd1, 3'b110, 5'd17, OPC_OPIMM), 5'd17, a | sext12(imm));
    op_check(enc_i(imm, 5'd1, 3'b111, 5'd18, OPC_OPIMM), 5'd18, a & sext12(imm));
    op_check(enc_i({7'h00, sh2}, 5'd1, 3'b001, 5'd19, OPC_OPIMM), 5'd19, a << sh2);
    op_check(enc_i({7'h00, sh2}, 5'd1, 3'b101, 5'd20, OPC_OPIMM), 5'd20, a >> sh2);
    op_check(enc_i({7'h20, sh2}, 5'd1, 3'b101, 5'd21, OPC_OPIMM), 5'd21,
             word_t'($signed(a) >>> sh2));
    op_check(enc_u(u[19:0], 5'd22, OPC_LUI), 5'd22, {u[19:0], 12'h000});
    op_check(enc_u(u[31:12], 5'd23, OPC_AUIPC), 5'd23, pc_of(pc_idx) + {u[31:12], 12'h000});
    run_program("arithmetic");
  endtask

  task automatic test_load_use();
    word_t a, b, la;
    begin_program();
    a = lcg_next();
    b = lcg_next();
    load_const(5'd1, a);
    load_const(5'd2, b);
    la = st_addr;
    store_expect(5'd1, a);
    emit(enc_i(la[11:0], 5'd0, 3'b010, 5'd3, OPC_LOAD));
    emit(enc_r(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
    store_expect(5'd4, a + b);
    // store data that depends on the load just before it
    emit(enc_i(la[11:0], 5'd0, 3'b010, 5'd5, OPC_LOAD));
    store_expect(5'd5, a);
    run_program("load-use");
  endtask

  task automatic test_branches();
    logic [2:0] f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    reg_idx_t rs1s [3] = '{5'd1, 5'd2, 5'd1};
    reg_idx_t rs2s [3] = '{5'd2, 5'd1, 5'd1};
    word_t vals [3];
    word_t x, y;
    int k;
    begin_program();
    vals[1] = 32'hFFFF_FFFB;
    vals[2] = 32'd3;
    load_const(5'd1, vals[1]);
    load_const(5'd2, vals[2]);
    k = 0;
    for (int f = 0; f < 6; f++) begin
      for (int p = 0; p < 3; p++) begin
        x = vals[rs1s[p]];
        y = vals[rs2s[p]];
        emit(enc_b(13'd12, rs2s[p], rs1s[p], f3s[f]));
        emit(enc_i(12'(k + 12'h100), 5'd0, 3'b000, 5'd6, OPC_OPIMM));
        emit(enc_s(st_addr[11:0], 5'd6, 5'd0));
        if (!branch_taken(f3s[f], x, y)) begin
          exp_addr.push_back(st_addr);
          exp_data.push_back(32'h100 + k);
        end
        st_addr += 4;
        emit(enc_i(12'(k + 12'h200), 5'd0, 3'b000, 5'd6, OPC_OPIMM));
        store_expect(5'd6, 32'h200 + k);
        k++;
      end
    end
    run_program("branches");
  endtask

  task automatic test_jumps();
    word_t jal_pc, jalr_pc, tgt;
    begin_program();
    jal_pc = pc_of(pc_idx);
    emit(enc_j(21'd12, 5'd1));
    emit_marker();
    store_expect(5'd1, jal_pc + 4);
    // odd base, the target needs bit 0 cleared to land aligned
    tgt = pc_of(pc_idx + 5);
    load_const(5'd6, tgt + 1);
    jalr_pc = pc_of(pc_idx);
    emit(enc_i(12'h000, 5'd6, 3'b000, 5'd7, OPC_JALR));
    emit_marker();
    store_expect(5'd7, jalr_pc + 4);
    run_program("jumps");
  endtask

  task automatic test_x0();
    word_t a;
    begin_program();
    a = lcg_next() | 32'h1;
    load_const(5'd1, a);
    emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, OPC_OPIMM));
    emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
    store_expect(5'd0, 32'h0);
    emit(enc_u(20'hABCDE, 5'd0, OPC_LUI));
    op_check(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd3), 5'd3, a);
    run_program("x0");
  endtask

  initial begin
    rst_n  = 1'b0;
    done   = 1'b0;
    errors = 0;
    pc_idx = 0;
    test_arith();
    test_load_use();
    test_branches();
    test_jumps();
    test_x0();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/rv_pkg.sv
hw/rv_if.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_hazard.sv
hw/rv_datapath.sv
hw/rv_core.sv
tests/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -sv -f filelist.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1
